/* src/cpu_cfg.svh */
`ifndef CPU_CFG_SVH
`define CPU_CFG_SVH

// Datapath and field widths
`define CPU_XLEN        32
`define CPU_REG_BITS    5
`define CPU_OP_BITS     5
`define CPU_FN_BITS     5
`define CPU_IMM_BITS    17
`define CPU_TARGET_BITS 27

// Opcodes, bits 31:27
`define CPU_OP_RTYPE 5'd0
`define CPU_OP_J     5'd1
`define CPU_OP_BNE   5'd2
`define CPU_OP_JAL   5'd3
`define CPU_OP_JR    5'd4
`define CPU_OP_ADDI  5'd5
`define CPU_OP_BLT   5'd6
`define CPU_OP_SW    5'd7
`define CPU_OP_LW    5'd8
`define CPU_OP_SETX  5'd21
`define CPU_OP_BEX   5'd22

// R-type function field, bits 6:2
`define CPU_FN_ADD 5'd0
`define CPU_FN_SUB 5'd1
`define CPU_FN_AND 5'd2
`define CPU_FN_OR  5'd3
`define CPU_FN_SLL 5'd4
`define CPU_FN_SRA 5'd5

`define CPU_REG_STATUS 5'd30 // Exception status, also setx/bex
`define CPU_REG_LINK   5'd31 // Return address for jal

// Values written to the status register on signed overflow
`define CPU_EXC_ADD  32'd1
`define CPU_EXC_ADDI 32'd2
`define CPU_EXC_SUB  32'd3

`endif

/* src/cpu_pkg.sv */
`include "cpu_cfg.svh"

package cpu_pkg;

    // Register-register layout
    typedef struct packed {
        logic [`CPU_OP_BITS-1:0]  opcode;
        logic [`CPU_REG_BITS-1:0] rd;
        logic [`CPU_REG_BITS-1:0] rs;
        logic [`CPU_REG_BITS-1:0] rt;
        logic [`CPU_REG_BITS-1:0] shamt;
        logic [`CPU_FN_BITS-1:0]  func;
        logic [1:0]               unused;
    } r_fields_t;

    // Immediate layout, used by addi, lw, sw and the branches
    typedef struct packed {
        logic [`CPU_OP_BITS-1:0]  opcode;
        logic [`CPU_REG_BITS-1:0] rd;
        logic [`CPU_REG_BITS-1:0] rs;
        logic [`CPU_IMM_BITS-1:0] imm;
    } i_fields_t;

    // Jump layout, used by j, jal, bex and setx
    typedef struct packed {
        logic [`CPU_OP_BITS-1:0]     opcode;
        logic [`CPU_TARGET_BITS-1:0] target;
    } j_fields_t;

    typedef union packed {
        r_fields_t r;
        i_fields_t i;
        j_fields_t j;
    } instr_t;

endpackage

/* src/fetch_stage.sv */
`include "cpu_cfg.svh"

module fetch_stage import cpu_pkg::*; (
    input  logic                 clock,
    input  logic                 fft_reset,
    input  logic                 redirect,     // Taken branch or jump from decode
    input  logic [`CPU_XLEN-1:0] redirect_pc,
    input  logic [`CPU_XLEN-1:0] q_imem,
    output logic [`CPU_XLEN-1:0] address_imem,
    output instr_t               if_instr,
    output logic [`CPU_XLEN-1:0] if_link
);

    logic [`CPU_XLEN-1:0] pc;
    logic [`CPU_XLEN-1:0] pc_plus_one;

    assign pc_plus_one  = pc + `CPU_XLEN'd1;
    assign address_imem = pc;

    always_ff @(posedge clock or posedge fft_reset) begin
        if (fft_reset) begin
            pc <= '0;
        end else begin
            pc <= redirect ? redirect_pc : pc_plus_one;
        end
    end

    // IF/ID instruction, the word fetched behind a redirect is dropped
    always_ff @(posedge clock or posedge fft_reset) begin
        if (fft_reset) begin
            if_instr <= '0;
        end else if (redirect) begin
            if_instr <= '0;                // NOP
        end else begin
            if_instr <= q_imem;
        end
    end

    // Address of the next instruction, used as link and branch base
    always_ff @(posedge clock) begin
        if_link <= pc_plus_one;
    end

endmodule

/* src/decode_stage.sv */
`include "cpu_cfg.svh"

module decode_stage import cpu_pkg::*; (
    input  logic                     clock,
    input  logic                     fft_reset,
    input  instr_t                   if_instr,
    input  logic [`CPU_XLEN-1:0]     if_link,
    input  logic [`CPU_XLEN-1:0]     data_read_reg_a,
    input  logic [`CPU_XLEN-1:0]     data_read_reg_b,
    output logic [`CPU_REG_BITS-1:0] ctrl_read_reg_a,
    output logic [`CPU_REG_BITS-1:0] ctrl_read_reg_b,
    output logic                     redirect,
    output logic [`CPU_XLEN-1:0]     redirect_pc,
    output instr_t                   ex_instr,
    output logic [`CPU_XLEN-1:0]     ex_a,
    output logic [`CPU_XLEN-1:0]     ex_b,
    output logic [`CPU_XLEN-1:0]     ex_link
);

    logic [`CPU_OP_BITS-1:0] opcode;
    logic                    is_bne, is_blt, is_j, is_jal, is_jr, is_bex, is_sw;
    logic                    is_branch;
    logic                    bne_taken, blt_taken, bex_taken;
    logic                    squash;
    logic [`CPU_XLEN-1:0]    branch_off;
    logic [`CPU_XLEN-1:0]    jump_target;

    assign opcode = if_instr.r.opcode;
    assign is_bne = (opcode == `CPU_OP_BNE);
    assign is_blt = (opcode == `CPU_OP_BLT);
    assign is_j   = (opcode == `CPU_OP_J);
    assign is_jal = (opcode == `CPU_OP_JAL);
    assign is_jr  = (opcode == `CPU_OP_JR);
    assign is_bex = (opcode == `CPU_OP_BEX);
    assign is_sw  = (opcode == `CPU_OP_SW);
    assign is_branch = is_bne | is_blt;

    // Branches compare rd against rs, sw reads its store data from rd
    assign ctrl_read_reg_a = is_bex ? `CPU_REG_STATUS :
                             (is_branch | is_jr) ? if_instr.r.rd : if_instr.r.rs;
    assign ctrl_read_reg_b = is_branch ? if_instr.r.rs :
                             is_sw ? if_instr.r.rd : if_instr.r.rt;

    assign branch_off = {{(`CPU_XLEN-`CPU_IMM_BITS){if_instr.i.imm[`CPU_IMM_BITS-1]}},
                         if_instr.i.imm};
    assign jump_target = {{(`CPU_XLEN-`CPU_TARGET_BITS){1'b0}}, if_instr.j.target};

    assign bne_taken = is_bne && (data_read_reg_a != data_read_reg_b);
    assign blt_taken = is_blt && ($signed(data_read_reg_a) < $signed(data_read_reg_b));
    assign bex_taken = is_bex && (data_read_reg_a != '0);

    assign redirect = bne_taken | blt_taken | is_j | is_jal | is_jr | bex_taken;

    always_comb begin
        if (is_branch) begin
            redirect_pc = if_link + branch_off;
        end else if (is_jr) begin
            redirect_pc = data_read_reg_a;
        end else begin
            redirect_pc = jump_target;      // j, jal, bex
        end
    end

    // Control transfers with no register result leave as NOPs
    assign squash = is_branch | is_j | is_jr | is_bex;

    always_ff @(posedge clock or posedge fft_reset) begin
        if (fft_reset) begin
            ex_instr <= '0;
        end else begin
            ex_instr <= squash ? '0 : if_instr;
        end
    end

    // Zero operands keep a squashed NOP from raising overflow
    always_ff @(posedge clock) begin
        ex_a    <= squash ? '0 : data_read_reg_a;
        ex_b    <= squash ? '0 : data_read_reg_b;
        ex_link <= if_link;
    end

endmodule

/* src/execute_stage.sv */
`include "cpu_cfg.svh"

module execute_stage import cpu_pkg::*; (
    input  logic                     clock,
    input  logic                     fft_reset,
    input  instr_t                   ex_instr,
    input  logic [`CPU_XLEN-1:0]     ex_a,
    input  logic [`CPU_XLEN-1:0]     ex_b,
    input  logic [`CPU_XLEN-1:0]     ex_link,
    output logic [`CPU_XLEN-1:0]     mem_result,
    output logic [`CPU_XLEN-1:0]     mem_store_data,
    output logic [`CPU_REG_BITS-1:0] mem_dest,
    output logic                     mem_write,
    output logic                     mem_load,
    output logic                     mem_store
);

    logic [`CPU_OP_BITS-1:0]  opcode;
    logic                     is_rtype, is_add, is_sub, is_addi;
    logic                     is_lw, is_sw, is_jal, is_setx;
    logic [`CPU_XLEN-1:0]     imm_ext, alu_b, sum, diff, alu_out, result;
    logic                     ovf_add, ovf_sub;
    logic [`CPU_REG_BITS-1:0] dest;

    assign opcode   = ex_instr.r.opcode;
    assign is_rtype = (opcode == `CPU_OP_RTYPE);
    assign is_add   = is_rtype && (ex_instr.r.func == `CPU_FN_ADD);
    assign is_sub   = is_rtype && (ex_instr.r.func == `CPU_FN_SUB);
    assign is_addi  = (opcode == `CPU_OP_ADDI);
    assign is_lw    = (opcode == `CPU_OP_LW);
    assign is_sw    = (opcode == `CPU_OP_SW);
    assign is_jal   = (opcode == `CPU_OP_JAL);
    assign is_setx  = (opcode == `CPU_OP_SETX);

    assign imm_ext = {{(`CPU_XLEN-`CPU_IMM_BITS){ex_instr.i.imm[`CPU_IMM_BITS-1]}},
                      ex_instr.i.imm};
    assign alu_b   = is_rtype ? ex_b : imm_ext;   // addi, lw, sw use the immediate
    assign sum     = ex_a + alu_b;
    assign diff    = ex_a - alu_b;

    // Signed overflow from operand and result sign bits
    assign ovf_add = (ex_a[`CPU_XLEN-1] == alu_b[`CPU_XLEN-1]) &&
                     (sum[`CPU_XLEN-1] != ex_a[`CPU_XLEN-1]);
    assign ovf_sub = (ex_a[`CPU_XLEN-1] != alu_b[`CPU_XLEN-1]) &&
                     (diff[`CPU_XLEN-1] != ex_a[`CPU_XLEN-1]);

    always_comb begin
        alu_out = sum;
        if (is_rtype) begin
            case (ex_instr.r.func)
                `CPU_FN_ADD: alu_out = sum;
                `CPU_FN_SUB: alu_out = diff;
                `CPU_FN_AND: alu_out = ex_a & ex_b;
                `CPU_FN_OR:  alu_out = ex_a | ex_b;
                `CPU_FN_SLL: alu_out = ex_a << ex_instr.r.shamt;
                `CPU_FN_SRA: alu_out = $signed(ex_a) >>> ex_instr.r.shamt;
                default:     alu_out = '0;
            endcase
        end
    end

    // Overflow redirects the write to the status register
    always_comb begin
        result = alu_out;
        dest   = ex_instr.r.rd;
        if (is_add && ovf_add) begin
            result = `CPU_EXC_ADD;
            dest   = `CPU_REG_STATUS;
        end else if (is_addi && ovf_add) begin
            result = `CPU_EXC_ADDI;
            dest   = `CPU_REG_STATUS;
        end else if (is_sub && ovf_sub) begin
            result = `CPU_EXC_SUB;
            dest   = `CPU_REG_STATUS;
        end else if (is_jal) begin
            result = ex_link;
            dest   = `CPU_REG_LINK;
        end else if (is_setx) begin
            result = {{(`CPU_XLEN-`CPU_TARGET_BITS){1'b0}}, ex_instr.j.target};
            dest   = `CPU_REG_STATUS;
        end
    end

    always_ff @(posedge clock or posedge fft_reset) begin
        if (fft_reset) begin
            mem_write <= 1'b0;
            mem_load  <= 1'b0;
            mem_store <= 1'b0;
        end else begin
            mem_write <= !is_sw && (dest != '0);   // r0 is never written
            mem_load  <= is_lw;
            mem_store <= is_sw;
        end
    end

    always_ff @(posedge clock) begin
        mem_result     <= result;
        mem_store_data <= ex_b;
        mem_dest       <= dest;
    end

endmodule

/* src/writeback_stage.sv */
`include "cpu_cfg.svh"

module writeback_stage import cpu_pkg::*; (
    input  logic                     clock,
    input  logic                     fft_reset,
    input  logic [`CPU_XLEN-1:0]     mem_result,
    input  logic [`CPU_XLEN-1:0]     mem_store_data,
    input  logic [`CPU_REG_BITS-1:0] mem_dest,
    input  logic                     mem_write,
    input  logic                     mem_load,
    input  logic                     mem_store,
    input  logic [`CPU_XLEN-1:0]     q_dmem,
    output logic [`CPU_XLEN-1:0]     address_dmem,
    output logic [`CPU_XLEN-1:0]     data,
    output logic                     wren,
    output logic                     ctrl_write_enable,
    output logic [`CPU_REG_BITS-1:0] ctrl_write_reg,
    output logic [`CPU_XLEN-1:0]     data_write_reg
);

    logic [`CPU_XLEN-1:0] wb_value;

    // Data memory is driven straight from EX/MEM
    assign address_dmem = mem_result;
    assign data         = mem_store_data;
    assign wren         = mem_store;

    // Load data arrives in the same cycle as the address
    assign wb_value = mem_load ? q_dmem : mem_result;

    always_ff @(posedge clock or posedge fft_reset) begin
        if (fft_reset) begin
            ctrl_write_enable <= 1'b0;
            ctrl_write_reg    <= '0;
        end else begin
            ctrl_write_enable <= mem_write;
            ctrl_write_reg    <= mem_dest;
        end
    end

    always_ff @(posedge clock) begin
        data_write_reg <= wb_value;
    end

endmodule

/* src/processor.sv */
`include "cpu_cfg.svh"

module processor import cpu_pkg::*; (
    input  logic                     clock,
    input  logic                     fft_reset,
    output logic [`CPU_XLEN-1:0]     address_imem,
    input  logic [`CPU_XLEN-1:0]     q_imem,
    output logic [`CPU_XLEN-1:0]     address_dmem,
    output logic [`CPU_XLEN-1:0]     data,
    output logic                     wren,
    input  logic [`CPU_XLEN-1:0]     q_dmem,
    output logic                     ctrl_write_enable,
    output logic [`CPU_REG_BITS-1:0] ctrl_write_reg,
    output logic [`CPU_REG_BITS-1:0] ctrl_read_reg_a,
    output logic [`CPU_REG_BITS-1:0] ctrl_read_reg_b,
    output logic [`CPU_XLEN-1:0]     data_write_reg,
    input  logic [`CPU_XLEN-1:0]     data_read_reg_a,
    input  logic [`CPU_XLEN-1:0]     data_read_reg_b
);

    instr_t                   if_instr, ex_instr;
    logic [`CPU_XLEN-1:0]     if_link, redirect_pc;
    logic                     redirect;
    logic [`CPU_XLEN-1:0]     ex_a, ex_b, ex_link;
    logic [`CPU_XLEN-1:0]     mem_result, mem_store_data;
    logic [`CPU_REG_BITS-1:0] mem_dest;
    logic                     mem_write, mem_load, mem_store;

    fetch_stage i_fetch (
        .clock, .fft_reset, .redirect, .redirect_pc, .q_imem,
        .address_imem, .if_instr, .if_link
    );

    decode_stage i_decode (
        .clock, .fft_reset, .if_instr, .if_link, .data_read_reg_a, .data_read_reg_b,
        .ctrl_read_reg_a, .ctrl_read_reg_b, .redirect, .redirect_pc,
        .ex_instr, .ex_a, .ex_b, .ex_link
    );

    execute_stage i_execute (
        .clock, .fft_reset, .ex_instr, .ex_a, .ex_b, .ex_link,
        .mem_result, .mem_store_data, .mem_dest, .mem_write, .mem_load, .mem_store
    );

    writeback_stage i_writeback (
        .clock, .fft_reset, .mem_result, .mem_store_data, .mem_dest,
        .mem_write, .mem_load, .mem_store, .q_dmem,
        .address_dmem, .data, .wren,
        .ctrl_write_enable, .ctrl_write_reg, .data_write_reg
    );

endmodule

/* bench/processor_props.sv */
`include "cpu_cfg.svh"

module processor_props (
    input logic                     clock,
    input logic                     fft_reset,
    input logic                     wren,
    input logic                     ctrl_write_enable,
    input logic [`CPU_REG_BITS-1:0] ctrl_write_reg
);
    timeunit 1ns;
    timeprecision 100ps;

    // Both write strobes are cleared asynchronously
    quiet_in_reset: assert property (@(posedge clock) fft_reset |-> !wren && !ctrl_write_enable)
        else $error("write strobe active during reset");

    one_write_kind: assert property (@(posedge clock) disable iff (fft_reset)
        !(wren && ctrl_write_enable))
        else $error("memory and register writes at once");

    no_r0_write: assert property (@(posedge clock) disable iff (fft_reset)
        ctrl_write_enable |-> ctrl_write_reg != '0)
        else $error("register write to r0");

endmodule

bind processor processor_props i_props (.*);

/* bench/tb_processor.sv */
`include "cpu_cfg.svh"

module tb_processor import cpu_pkg::*; ();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int PROG_WORDS = 67;               // All five programs with their halt loops
    localparam int TIMEOUT_NS = (PROG_WORDS * 8 + 5 * 16) * 8;

    logic        clock, fft_reset, wren, ctrl_write_enable;
    logic [31:0] address_imem, q_imem, address_dmem, data, q_dmem;
    logic [31:0] data_write_reg, data_read_reg_a, data_read_reg_b;
    logic [4:0]  ctrl_write_reg, ctrl_read_reg_a, ctrl_read_reg_b;

    logic [31:0] imem [64];
    logic [31:0] dmem [256];
    logic [31:0] regs [32];
    logic [31:0] fetch_pc[$];                     // Fetch address of every cycle
    instr_t      fetch_word[$];                   // Word seen at that address
    logic [15:0] lfsr = 16'd12148;
    int          wp, halt_addr, error_count;
    logic [4:0]  exp_reg[$], got_reg[$];
    logic [31:0] exp_val[$], got_val[$], exp_sa[$], exp_sd[$], got_sa[$], got_sd[$];

    processor i_processor (.*);

    initial begin
        clock = 1'b0;
        forever #4 clock = ~clock;
    end

    assign q_imem = imem[address_imem[5:0]];
    assign q_dmem = dmem[address_dmem[7:0]];

    always @(posedge clock) begin
        if (wren) dmem[address_dmem[7:0]] <= data;
        if (ctrl_write_enable && ctrl_write_reg != 5'd0) regs[ctrl_write_reg] <= data_write_reg;
    end

    // Register file reads write through, r0 always zero
    always_comb begin
        data_read_reg_a = regs[ctrl_read_reg_a];
        if (ctrl_write_enable && ctrl_write_reg == ctrl_read_reg_a)
            data_read_reg_a = data_write_reg;
        if (ctrl_read_reg_a == 5'd0) data_read_reg_a = '0;
        data_read_reg_b = regs[ctrl_read_reg_b];
        if (ctrl_write_enable && ctrl_write_reg == ctrl_read_reg_b)
            data_read_reg_b = data_write_reg;
        if (ctrl_read_reg_b == 5'd0) data_read_reg_b = '0;
    end

    // Outputs are sampled mid-cycle
    always @(negedge clock) begin
        if (!fft_reset) begin
            if (ctrl_write_enable) begin
                got_reg.push_back(ctrl_write_reg);
                got_val.push_back(data_write_reg);
            end
            if (wren) begin
                got_sa.push_back(address_dmem);
                got_sd.push_back(data);
            end
            fetch_pc.push_back(address_imem);
            fetch_word.push_back(q_imem);
        end
    end

    function automatic logic [31:0] rand_bits(int n);
        logic [31:0] v;
        logic        b;
        v = '0;
        for (int k = 0; k < n; k++) begin
            b = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
            lfsr = {lfsr[14:0], b};
            v = {v[30:0], b};
        end
        return v;
    endfunction

    function automatic instr_t enc_r(logic [4:0] fn, logic [4:0] rd, logic [4:0] rs,
                                     logic [4:0] rt, logic [4:0] sh);
        instr_t w;
        w = '0;
        w.r.opcode = `CPU_OP_RTYPE;
        w.r.rd     = rd;
        w.r.rs     = rs;
        w.r.rt     = rt;
        w.r.shamt  = sh;
        w.r.func   = fn;
        return w;
    endfunction

    function automatic instr_t enc_i(logic [4:0] op, logic [4:0] rd, logic [4:0] rs,
                                     logic [16:0] imm);
        instr_t w;
        w.i.opcode = op;
        w.i.rd     = rd;
        w.i.rs     = rs;
        w.i.imm    = imm;
        return w;
    endfunction

    function automatic instr_t enc_j(logic [4:0] op, logic [26:0] target);
        instr_t w;
        w.j.opcode = op;
        w.j.target = target;
        return w;
    endfunction

    task automatic fail_check(string msg);
        error_count++;
        $display("CHECK FAILED at %0t: %s", $time, msg);
        $display("STATUS: FAIL");
        $fatal(1);
    endtask

    task automatic check_write(logic [4:0] got_r, logic [31:0] got_v,
                               logic [4:0] want_r, logic [31:0] want_v);
        if (got_r !== want_r || got_v !== want_v)
            fail_check($sformatf("write r%0d=%h, expected r%0d=%h",
                                 got_r, got_v, want_r, want_v));
    endtask

    task automatic check_store(logic [31:0] got_a, logic [31:0] got_d,
                               logic [31:0] want_a, logic [31:0] want_d);
        if (got_a !== want_a || got_d !== want_d)
            fail_check($sformatf("store %h@%h, expected %h@%h", got_d, got_a, want_d, want_a));
    endtask

    task automatic check_instr(int addr, instr_t got, instr_t want);
        if (got !== want)
            fail_check($sformatf("fetched %h at %0d, expected %h", got, addr, want));
    endtask

    // The word fetched two cycles after ctl_pc, behind the one dropped slot
    task automatic check_second_fetch(logic [31:0] ctl_pc, int addr, instr_t want);
        int k;
        k = 0;
        while (k < fetch_pc.size() && fetch_pc[k] != ctl_pc) k++;
        if (k + 2 >= fetch_pc.size())
            fail_check($sformatf("no two fetches after address %0d", ctl_pc));
        check_instr(addr, fetch_word[k + 2], want);
    endtask

    task automatic emit(instr_t w);
        imem[wp] = w;
        wp++;
    endtask

    task automatic expect_write(logic [4:0] r, logic [31:0] v);
        exp_reg.push_back(r);
        exp_val.push_back(v);
    endtask

    // Holds reset and clears models and queues before a program is loaded
    task automatic begin_test();
        @(posedge clock);
        fft_reset <= 1'b1;
        @(posedge clock);
        for (int k = 0; k < 64; k++) imem[k] = enc_j(`CPU_OP_J, k);   // Self loop everywhere
        for (int k = 0; k < 256; k++) dmem[k] = ~k;
        for (int k = 0; k < 32; k++) regs[k] = '0;
        exp_reg.delete();
        exp_val.delete();
        got_reg.delete();
        got_val.delete();
        exp_sa.delete();
        exp_sd.delete();
        got_sa.delete();
        got_sd.delete();
        fetch_pc.delete();
        fetch_word.delete();
        wp = 0;
    endtask

    task automatic run_program();
        halt_addr = wp;
        emit(enc_j(`CPU_OP_J, wp));
        repeat (7) @(posedge clock);
        fft_reset <= 1'b0;
        @(negedge clock);
        while (address_imem != halt_addr) @(negedge clock);
        repeat (6) @(negedge clock);                  // Drain the pipeline
        if (got_reg.size() != exp_reg.size())
            fail_check($sformatf("saw %0d register writes, expected %0d",
                                 got_reg.size(), exp_reg.size()));
        foreach (exp_reg[k]) check_write(got_reg[k], got_val[k], exp_reg[k], exp_val[k]);
        if (got_sa.size() != exp_sa.size())
            fail_check($sformatf("saw %0d stores, expected %0d", got_sa.size(), exp_sa.size()));
        foreach (exp_sa[k]) check_store(got_sa[k], got_sd[k], exp_sa[k], exp_sd[k]);
    endtask

    task automatic test_alu();
        logic [31:0] a, b, na, sh;
        begin_test();
        a  = rand_bits(15);
        b  = rand_bits(15);
        sh = rand_bits(5);
        na = -a;
        emit(enc_i(`CPU_OP_ADDI, 1, 0, a[16:0]));
        emit(enc_i(`CPU_OP_ADDI, 2, 0, b[16:0]));
        emit(enc_i(`CPU_OP_ADDI, 3, 0, na[16:0]));
        emit('0);
        emit('0);
        emit(enc_r(`CPU_FN_ADD, 4, 1, 2, 0));
        emit(enc_r(`CPU_FN_SUB, 5, 1, 2, 0));
        emit(enc_r(`CPU_FN_AND, 6, 1, 2, 0));
        emit(enc_r(`CPU_FN_OR,  7, 1, 2, 0));
        emit(enc_r(`CPU_FN_SLL, 8, 1, 0, sh[4:0]));
        emit(enc_r(`CPU_FN_SRA, 9, 3, 0, sh[4:0]));
        expect_write(1, a);
        expect_write(2, b);
        expect_write(3, na);
        expect_write(4, a + b);
        expect_write(5, a - b);
        expect_write(6, a & b);
        expect_write(7, a | b);
        expect_write(8, a << sh);
        expect_write(9, $signed(na) >>> sh);
        run_program();
    endtask

    task automatic test_overflow();
        begin_test();
        emit(enc_i(`CPU_OP_ADDI, 1, 0, 17'd1));
        emit('0);
        emit('0);
        emit(enc_r(`CPU_FN_SLL, 2, 1, 0, 30));
        emit(enc_r(`CPU_FN_SLL, 4, 1, 0, 31));
        emit('0);
        emit('0);
        emit(enc_r(`CPU_FN_ADD, 3, 2, 2, 0));      // Positive plus positive wraps
        emit(enc_r(`CPU_FN_SUB, 5, 4, 1, 0));      // Most negative minus one
        emit(enc_i(`CPU_OP_ADDI, 6, 4, '1));
        emit(enc_j(`CPU_OP_SETX, 27'd12345));
        expect_write(1, 32'd1);
        expect_write(2, 32'h4000_0000);
        expect_write(4, 32'h8000_0000);
        expect_write(30, 32'd1);
        expect_write(30, 32'd3);
        expect_write(30, 32'd2);
        expect_write(30, 32'd12345);
        run_program();
    endtask

    task automatic test_memory();
        logic [31:0] d;
        begin_test();
        d = rand_bits(16);
        emit(enc_i(`CPU_OP_ADDI, 1, 0, 17'd100));
        emit(enc_i(`CPU_OP_ADDI, 2, 0, d[16:0]));
        emit('0);
        emit('0);
        emit(enc_i(`CPU_OP_SW, 2, 1, 17'd4));
        emit(enc_i(`CPU_OP_LW, 3, 1, 17'd4));
        expect_write(1, 32'd100);
        expect_write(2, d);
        expect_write(3, d);
        exp_sa.push_back(32'd104);
        exp_sd.push_back(d);
        run_program();
    endtask

    task automatic test_branches();
        begin_test();
        emit(enc_i(`CPU_OP_ADDI, 1, 0, 17'd5));
        emit(enc_i(`CPU_OP_ADDI, 2, 0, 17'd7));
        emit('0);
        emit('0);
        emit(enc_i(`CPU_OP_BNE, 1, 2, 17'd2));     // Taken to 7
        emit(enc_i(`CPU_OP_ADDI, 10, 0, 17'd1));
        emit(enc_i(`CPU_OP_ADDI, 11, 0, 17'd1));
        emit(enc_i(`CPU_OP_ADDI, 12, 0, 17'd2));
        emit(enc_i(`CPU_OP_BLT, 2, 1, 17'd1));     // 7 < 5 fails
        emit(enc_i(`CPU_OP_ADDI, 13, 0, 17'd3));
        emit(enc_i(`CPU_OP_ADDI, 14, 0, 17'd4));
        emit(enc_i(`CPU_OP_BLT, 1, 2, 17'd1));     // Taken to 13
        emit(enc_i(`CPU_OP_ADDI, 15, 0, 17'd5));
        emit(enc_i(`CPU_OP_ADDI, 16, 0, 17'd6));
        emit(enc_i(`CPU_OP_BNE, 1, 1, 17'd1));
        emit(enc_i(`CPU_OP_ADDI, 17, 0, 17'd7));
        emit(enc_i(`CPU_OP_ADDI, 18, 0, 17'd8));
        expect_write(1, 32'd5);
        expect_write(2, 32'd7);
        expect_write(12, 32'd2);
        expect_write(13, 32'd3);
        expect_write(14, 32'd4);
        expect_write(16, 32'd6);
        expect_write(17, 32'd7);
        expect_write(18, 32'd8);
        run_program();
        check_second_fetch(4, 7, enc_i(`CPU_OP_ADDI, 12, 0, 17'd2));
        check_second_fetch(8, 10, enc_i(`CPU_OP_ADDI, 14, 0, 17'd4));
        check_second_fetch(11, 13, enc_i(`CPU_OP_ADDI, 16, 0, 17'd6));
        check_second_fetch(14, 16, enc_i(`CPU_OP_ADDI, 18, 0, 17'd8));
    endtask

    task automatic test_jumps();
        begin_test();
        emit(enc_i(`CPU_OP_ADDI, 1, 0, 17'd7));
        emit('0);
        emit('0);
        emit(enc_j(`CPU_OP_J, 27'd5));
        emit(enc_i(`CPU_OP_ADDI, 10, 0, 17'd1));
        emit(enc_i(`CPU_OP_JR, 1, 0, 17'd0));      // Jumps to r1
        emit(enc_i(`CPU_OP_ADDI, 11, 0, 17'd1));
        emit(enc_j(`CPU_OP_JAL, 27'd9));
        emit(enc_i(`CPU_OP_ADDI, 12, 0, 17'd1));
        emit(enc_j(`CPU_OP_BEX, 27'd12));          // r30 still zero
        emit(enc_i(`CPU_OP_ADDI, 13, 0, 17'd1));
        emit(enc_j(`CPU_OP_SETX, 27'd1));
        emit('0);
        emit('0);
        emit(enc_j(`CPU_OP_BEX, 27'd16));
        emit(enc_i(`CPU_OP_ADDI, 14, 0, 17'd1));
        emit(enc_i(`CPU_OP_ADDI, 15, 0, 17'd2));
        expect_write(1, 32'd7);
        expect_write(31, 32'd8);
        expect_write(13, 32'd1);
        expect_write(30, 32'd1);
        expect_write(15, 32'd2);
        run_program();
        check_second_fetch(3, 5, enc_i(`CPU_OP_JR, 1, 0, 17'd0));
        check_second_fetch(5, 7, enc_j(`CPU_OP_JAL, 27'd9));
        check_second_fetch(7, 9, enc_j(`CPU_OP_BEX, 27'd12));
        check_second_fetch(14, 16, enc_i(`CPU_OP_ADDI, 15, 0, 17'd2));
    endtask

    initial begin
        #(TIMEOUT_NS * 1ns);
        $display("Timeout: the programs did not reach their final loop in time");
        $display("STATUS: FAIL");
        $fatal(1);
    end

    initial begin
        fft_reset   = 1'b1;
        error_count = 0;
        test_alu();
        test_overflow();
        test_memory();
        test_branches();
        test_jumps();
        if (error_count == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

/* flist.f */
+incdir+src
src/cpu_pkg.sv
src/fetch_stage.sv
src/decode_stage.sv
src/execute_stage.sv
src/writeback_stage.sv
src/processor.sv
bench/processor_props.sv
bench/tb_processor.sv

/* Bender.yml */
package:
  name: processor

sources:
  - include_dirs:
      - src
    files:
      - src/cpu_pkg.sv
      - src/fetch_stage.sv
      - src/decode_stage.sv
      - src/execute_stage.sv
      - src/writeback_stage.sv
      - src/processor.sv
  - target: test
    include_dirs:
      - src
    files:
      - bench/processor_props.sv
      - bench/tb_processor.sv
